//--- design/app_bus_pkg.sv
// ------------------
// Address map, timer register map and response codes of the application bus
// Byte addresses on the bus, word offsets inside each core
// ------------------
package app_bus_pkg;

  // Top two address bits select the area
  localparam logic [1:0] area_reserved_a = 2'h0;
  localparam logic [1:0] area_ram        = 2'h1;
  localparam logic [1:0] area_reserved_b = 2'h2;
  localparam logic [1:0] area_mmio       = 2'h3;

  // Core prefix inside the MMIO area
  localparam logic [5:0] timer_prefix = 6'h01;

  // Timer register word offsets
  localparam logic [7:0] timer_ctrl      = 8'h00;
  localparam logic [7:0] timer_status    = 8'h01;
  localparam logic [7:0] timer_prescaler = 8'h02;
  localparam logic [7:0] timer_initial   = 8'h03;
  localparam logic [7:0] timer_current   = 8'h04;

  localparam int ctrl_start_bit     = 0;
  localparam int ctrl_stop_bit      = 1;
  localparam int status_running_bit = 0;

  localparam logic [1:0] resp_okay   = 2'b00;
  localparam logic [1:0] resp_slverr = 2'b10;

  // Same address word, seen as a plain area offset or as an MMIO register
  typedef union packed {
    struct packed {
      logic [1:0]  area;
      logic [29:0] offset;
    } area_view;
    struct packed {
      logic [1:0]  area;
      logic [5:0]  core;
      logic [15:0] unused;
      logic [7:0]  reg_offset;
    } mmio_view;
  } addr_word_u;

endpackage

//--- design/app_subsystem.sv
// ------------------
// Application bus top with one AXI4-Lite slave port
// RAM in area 1, timer in the MMIO area
// ------------------
`timescale 1ns/1ps

module app_subsystem #(
  parameter int ram_addr_bits = 8
) (
  input  logic        clk,
  input  logic        reset_n,
  input  logic [31:0] awaddr,
  input  logic        awvalid,
  output logic        awready,
  input  logic [31:0] wdata,
  input  logic [3:0]  wstrb,
  input  logic        wvalid,
  output logic        wready,
  output logic [1:0]  bresp,
  output logic        bvalid,
  input  logic        bready,
  input  logic [31:0] araddr,
  input  logic        arvalid,
  output logic        arready,
  output logic [31:0] rdata,
  output logic [1:0]  rresp,
  output logic        rvalid,
  input  logic        rready
);

  // Internal request between front end and decoder
  logic                    req_valid;
  app_bus_pkg::addr_word_u req_addr;
  logic [31:0]             req_wdata;
  logic [3:0]              req_wstrb;
  logic                    resp_ready;
  logic [31:0]             resp_rdata;
  logic                    resp_err;

  core_bus_if #(.addr_bits(ram_addr_bits)) ram_bus ();
  core_bus_if                              timer_bus ();

  axil_frontend u_axil_frontend (
    .clk        (clk),
    .reset_n    (reset_n),
    .awaddr     (awaddr),
    .awvalid    (awvalid),
    .awready    (awready),
    .wdata      (wdata),
    .wstrb      (wstrb),
    .wvalid     (wvalid),
    .wready     (wready),
    .bresp      (bresp),
    .bvalid     (bvalid),
    .bready     (bready),
    .araddr     (araddr),
    .arvalid    (arvalid),
    .arready    (arready),
    .rdata      (rdata),
    .rresp      (rresp),
    .rvalid     (rvalid),
    .rready     (rready),
    .req_valid  (req_valid),
    .req_addr   (req_addr),
    .req_wdata  (req_wdata),
    .req_wstrb  (req_wstrb),
    .resp_ready (resp_ready),
    .resp_rdata (resp_rdata),
    .resp_err   (resp_err)
  );

  mem_decode #(.ram_addr_bits(ram_addr_bits)) u_mem_decode (
    .clk        (clk),
    .reset_n    (reset_n),
    .req_valid  (req_valid),
    .req_addr   (req_addr),
    .req_wdata  (req_wdata),
    .req_wstrb  (req_wstrb),
    .resp_ready (resp_ready),
    .resp_rdata (resp_rdata),
    .resp_err   (resp_err),
    .ram_bus    (ram_bus.controller),
    .timer_bus  (timer_bus.controller)
  );

  ram_core #(.ram_addr_bits(ram_addr_bits)) u_ram_core (
    .clk     (clk),
    .reset_n (reset_n),
    .bus     (ram_bus.core)
  );

  timer_core u_timer_core (
    .clk     (clk),
    .reset_n (reset_n),
    .bus     (timer_bus.core)
  );

endmodule

//--- design/axil_frontend.sv
// ------------------
// AXI4-Lite slave, one transaction in flight at a time
// Writes win over reads when both arrive together
// No new address is taken while a response is held
// ------------------
`timescale 1ns/1ps

module axil_frontend (
  input  logic                    clk,
  input  logic                    reset_n,
  input  logic [31:0]             awaddr,
  input  logic                    awvalid,
  output logic                    awready,
  input  logic [31:0]             wdata,
  input  logic [3:0]              wstrb,
  input  logic                    wvalid,
  output logic                    wready,
  output logic [1:0]              bresp,
  output logic                    bvalid,
  input  logic                    bready,
  input  logic [31:0]             araddr,
  input  logic                    arvalid,
  output logic                    arready,
  output logic [31:0]             rdata,
  output logic [1:0]              rresp,
  output logic                    rvalid,
  input  logic                    rready,
  output logic                    req_valid,
  output app_bus_pkg::addr_word_u req_addr,
  output logic [31:0]             req_wdata,
  output logic [3:0]              req_wstrb,
  input  logic                    resp_ready,
  input  logic [31:0]             resp_rdata,
  input  logic                    resp_err
);

  localparam logic [2:0] st_idle    = 3'd0;
  localparam logic [2:0] st_wr_req  = 3'd1;
  localparam logic [2:0] st_rd_req  = 3'd2;
  localparam logic [2:0] st_wr_resp = 3'd3;
  localparam logic [2:0] st_rd_resp = 3'd4;

  logic [2:0]  state;
  logic [1:0]  resp_code;
  logic [31:0] rdata_reg;
  logic        write_accept;
  logic        read_accept;

  assign write_accept = (state == st_idle) && awvalid && wvalid;
  assign read_accept  = (state == st_idle) && arvalid && !(awvalid && wvalid);

  assign awready   = write_accept;
  assign wready    = write_accept;
  assign arready   = read_accept;
  assign req_valid = (state == st_wr_req) || (state == st_rd_req);
  assign bvalid    = (state == st_wr_resp);
  assign rvalid    = (state == st_rd_resp);
  assign bresp     = resp_code;
  assign rresp     = resp_code;
  assign rdata     = rdata_reg;

  // --------------------
  // Transaction FSM
  // --------------------
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      state <= st_idle;
    end else begin
      case (state)
        st_idle: begin
          if (write_accept) begin
            state <= st_wr_req;
          end else if (read_accept) begin
            state <= st_rd_req;
          end
        end
        st_wr_req:  if (resp_ready) state <= st_wr_resp;
        st_rd_req:  if (resp_ready) state <= st_rd_resp;
        st_wr_resp: if (bready) state <= st_idle;
        st_rd_resp: if (rready) state <= st_idle;
        default:    state <= st_idle;
      endcase
    end
  end

  // Request held stable from handshake until the decoder answers
  always_ff @(posedge clk) begin
    if (write_accept) begin
      req_addr  <= awaddr;
      req_wdata <= wdata;
      req_wstrb <= wstrb;
    end else if (read_accept) begin
      req_addr  <= araddr;
      req_wdata <= 32'h0;
      // Zero strobes mark a read downstream
      req_wstrb <= 4'h0;
    end

    if (req_valid && resp_ready) begin
      resp_code <= resp_err ? app_bus_pkg::resp_slverr : app_bus_pkg::resp_okay;
      rdata_reg <= resp_rdata;
    end
  end

endmodule

//--- design/core_bus_if.sv
// ------------------
// Chip-select bus from the decoder to one core
// cs stays high until the core answers with ready
// ------------------
`timescale 1ns/1ps

interface core_bus_if #(
  parameter int addr_bits = 8
) ();

  logic                 cs;
  logic                 we;
  logic [addr_bits-1:0] address;
  logic [31:0]          write_data;
  logic [3:0]           byte_en;
  logic [31:0]          read_data;
  logic                 ready;

  modport controller (
    output cs, we, address, write_data, byte_en,
    input  read_data, ready
  );

  modport core (
    input  cs, we, address, write_data, byte_en,
    output read_data, ready
  );

endinterface

//--- design/mem_decode.sv
// ------------------
// Area and core decode with one registered response
// Reserved areas and unmapped cores answer next cycle with an error
// ------------------
`timescale 1ns/1ps

module mem_decode #(
  parameter int ram_addr_bits = 8
) (
  input  logic                    clk,
  input  logic                    reset_n,
  input  logic                    req_valid,
  input  app_bus_pkg::addr_word_u req_addr,
  input  logic [31:0]             req_wdata,
  input  logic [3:0]              req_wstrb,
  output logic                    resp_ready,
  output logic [31:0]             resp_rdata,
  output logic                    resp_err,
  core_bus_if.controller          ram_bus,
  core_bus_if.controller          timer_bus
);

  logic        resp_ready_reg;
  logic        resp_ready_new;
  logic [31:0] resp_rdata_reg;
  logic [31:0] resp_rdata_new;
  logic        resp_err_reg;
  logic        resp_err_new;

  assign resp_ready = resp_ready_reg;
  assign resp_rdata = resp_rdata_reg;
  assign resp_err   = resp_err_reg;

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      resp_ready_reg <= 1'b0;
    end else begin
      resp_ready_reg <= resp_ready_new;
    end
    resp_rdata_reg <= resp_rdata_new;
    resp_err_reg   <= resp_err_new;
  end

  // --------------------
  // Decode and mux
  // --------------------
  always_comb begin
    resp_ready_new = 1'b0;
    resp_rdata_new = 32'h0;
    resp_err_new   = 1'b0;

    ram_bus.cs         = 1'b0;
    ram_bus.we         = |req_wstrb;
    ram_bus.address    = req_addr.area_view.offset[ram_addr_bits+1:2];
    ram_bus.write_data = req_wdata;
    ram_bus.byte_en    = req_wstrb;

    timer_bus.cs         = 1'b0;
    timer_bus.we         = |req_wstrb;
    timer_bus.address    = {2'b00, req_addr.mmio_view.reg_offset[7:2]};
    timer_bus.write_data = req_wdata;
    timer_bus.byte_en    = req_wstrb;

    // Gate on the registered ready so a request is answered only once
    if (req_valid && !resp_ready_reg) begin
      case (req_addr.area_view.area)
        app_bus_pkg::area_ram: begin
          ram_bus.cs     = 1'b1;
          resp_rdata_new = ram_bus.read_data;
          resp_ready_new = ram_bus.ready;
        end
        app_bus_pkg::area_mmio: begin
          if (req_addr.mmio_view.core == app_bus_pkg::timer_prefix) begin
            timer_bus.cs   = 1'b1;
            resp_rdata_new = timer_bus.read_data;
            resp_ready_new = timer_bus.ready;
          end else begin
            resp_ready_new = 1'b1;
            resp_err_new   = 1'b1;
          end
        end
        default: begin
          resp_ready_new = 1'b1;
          resp_err_new   = 1'b1;
        end
      endcase
    end
  end

endmodule

//--- design/ram_core.sv
// ------------------
// Word RAM, 2**ram_addr_bits words of 32 bits
// Ready pulses one cycle after cs, write lands on that cycle
// ------------------
`timescale 1ns/1ps

module ram_core #(
  parameter int ram_addr_bits = 8
) (
  input  logic     clk,
  input  logic     reset_n,
  core_bus_if.core bus
);

  logic [31:0] mem [2**ram_addr_bits];
  logic        ready_reg;
  logic [31:0] read_data_reg;

  assign bus.ready     = ready_reg;
  assign bus.read_data = read_data_reg;

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      ready_reg <= 1'b0;
    end else begin
      ready_reg <= bus.cs && !ready_reg;
    end
  end

  always_ff @(posedge clk) begin
    if (bus.cs) begin
      read_data_reg <= mem[bus.address];
    end
    // Per-byte write, taken with the ready cycle
    if (bus.cs && bus.we && ready_reg) begin
      for (int i = 0; i < 4; i++) begin
        if (bus.byte_en[i]) begin
          mem[bus.address][i*8 +: 8] <= bus.write_data[i*8 +: 8];
        end
      end
    end
  end

endmodule

//--- design/timer_core.sv
// ------------------
// Countdown timer, one tick every prescaler+1 cycles
// Prescaler and initial are locked while running
// ------------------
`timescale 1ns/1ps

module timer_core (
  input  logic     clk,
  input  logic     reset_n,
  core_bus_if.core bus
);

  logic        running;
  logic [31:0] prescaler;
  logic [31:0] initial_value;
  logic [31:0] current;
  logic [31:0] prescale_ctr;

  // Registers answer in the same cycle
  assign bus.ready = bus.cs;

  always_comb begin
    bus.read_data = 32'h0;
    case (bus.address)
      app_bus_pkg::timer_status:
        bus.read_data[app_bus_pkg::status_running_bit] = running;
      app_bus_pkg::timer_prescaler: bus.read_data = prescaler;
      app_bus_pkg::timer_initial:   bus.read_data = initial_value;
      app_bus_pkg::timer_current:   bus.read_data = current;
      default:                      bus.read_data = 32'h0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      running       <= 1'b0;
      prescaler     <= 32'h0;
      initial_value <= 32'h0;
      current       <= 32'h0;
      prescale_ctr  <= 32'h0;
    end else begin
      // --------------------
      // Countdown
      // --------------------
      if (running) begin
        if (prescale_ctr == prescaler) begin
          prescale_ctr <= 32'h0;
          if (current != 32'h0) current <= current - 32'h1;
          if (current <= 32'h1) running <= 1'b0;
        end else begin
          prescale_ctr <= prescale_ctr + 32'h1;
        end
      end

      // Bus writes override the countdown, stop wins over start
      if (bus.cs && bus.we) begin
        case (bus.address)
          app_bus_pkg::timer_ctrl: begin
            if (bus.write_data[app_bus_pkg::ctrl_start_bit]) begin
              current      <= initial_value;
              prescale_ctr <= 32'h0;
              running      <= 1'b1;
            end
            if (bus.write_data[app_bus_pkg::ctrl_stop_bit]) running <= 1'b0;
          end
          app_bus_pkg::timer_prescaler: if (!running) prescaler <= bus.write_data;
          app_bus_pkg::timer_initial:   if (!running) initial_value <= bus.write_data;
          default: ;
        endcase
      end
    end
  end

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# Compile and run the testbench with Verilator from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sim.f --top-module app_subsystem_tb \
  -o app_subsystem_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

output=$(./obj_dir/app_subsystem_sim 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -qx "All checks passed"; then
  exit 0
else
  exit 1
fi

//--- sim.f
design/app_bus_pkg.sv
design/core_bus_if.sv
design/axil_frontend.sv
design/mem_decode.sv
design/ram_core.sv
design/timer_core.sv
design/app_subsystem.sv
test/app_subsystem_assertions.sv
test/app_subsystem_tb.sv

//--- test/app_subsystem_assertions.sv
// ------------------
// AXI4-Lite and internal request handshake properties
// Bound into the top level, checked only out of reset
// ------------------
`timescale 1ns/1ps

module app_subsystem_assertions (
  input logic clk,
  input logic reset_n,
  input logic awvalid,
  input logic awready,
  input logic wvalid,
  input logic wready,
  input logic arvalid,
  input logic arready,
  input logic bvalid,
  input logic bready,
  input logic rvalid,
  input logic rready,
  input logic req_valid,
  input logic resp_ready
);

  // Set from read address handshake until read data handshake
  logic read_open;

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      read_open <= 1'b0;
    end else if (arvalid && arready) begin
      read_open <= 1'b1;
    end else if (rvalid && rready) begin
      read_open <= 1'b0;
    end
  end

  aw_held: assert property (@(posedge clk) disable iff (!reset_n)
    awvalid && !awready |=> awvalid) else $error("awvalid dropped before awready");

  w_held: assert property (@(posedge clk) disable iff (!reset_n)
    wvalid && !wready |=> wvalid) else $error("wvalid dropped before wready");

  ar_held: assert property (@(posedge clk) disable iff (!reset_n)
    arvalid && !arready |=> arvalid) else $error("arvalid dropped before arready");

  req_held: assert property (@(posedge clk) disable iff (!reset_n)
    req_valid && !resp_ready |=> req_valid) else $error("request dropped before response");

  b_held: assert property (@(posedge clk) disable iff (!reset_n)
    bvalid && !bready |=> bvalid) else $error("bvalid dropped before bready");

  r_held: assert property (@(posedge clk) disable iff (!reset_n)
    rvalid && !rready |=> rvalid) else $error("rvalid dropped before rready");

  r_after_ar: assert property (@(posedge clk) disable iff (!reset_n)
    rvalid |-> read_open) else $error("read response without an accepted read");

endmodule

//--- test/app_subsystem_tb.sv
// ------------------
// Replays test/bus_vectors.txt, then a random RAM sweep and a timer lock test
// Run from the project root so the vector path resolves
// ------------------
`timescale 1ns/1ps

module app_subsystem_tb;

  localparam int          ram_addr_bits   = 8;
  localparam int          hs_timeout      = 50;
  localparam int          poll_limit      = 2000;
  localparam logic [31:0] ram_base        = 32'h4000_0000;
  localparam logic [31:0] timer_ctrl_addr = 32'hc100_0000;
  localparam logic [31:0] timer_stat_addr = 32'hc100_0004;
  localparam logic [31:0] timer_pre_addr  = 32'hc100_0008;
  localparam logic [31:0] timer_init_addr = 32'hc100_000c;
  localparam logic [31:0] timer_cur_addr  = 32'hc100_0010;

  logic        clk;
  logic        reset_n;
  logic [31:0] awaddr;
  logic        awvalid;
  logic        awready;
  logic [31:0] wdata;
  logic [3:0]  wstrb;
  logic        wvalid;
  logic        wready;
  logic [1:0]  bresp;
  logic        bvalid;
  logic        bready;
  logic [31:0] araddr;
  logic        arvalid;
  logic        arready;
  logic [31:0] rdata;
  logic [1:0]  rresp;
  logic        rvalid;
  logic        rready;

  int          errors;
  logic [31:0] rng_state;
  // Last word written to each RAM location by the sweep
  logic [31:0] shadow [2**ram_addr_bits];

  app_subsystem #(.ram_addr_bits(ram_addr_bits)) u_app_subsystem (
    .clk     (clk),
    .reset_n (reset_n),
    .awaddr  (awaddr),
    .awvalid (awvalid),
    .awready (awready),
    .wdata   (wdata),
    .wstrb   (wstrb),
    .wvalid  (wvalid),
    .wready  (wready),
    .bresp   (bresp),
    .bvalid  (bvalid),
    .bready  (bready),
    .araddr  (araddr),
    .arvalid (arvalid),
    .arready (arready),
    .rdata   (rdata),
    .rresp   (rresp),
    .rvalid  (rvalid),
    .rready  (rready)
  );

  bind app_subsystem app_subsystem_assertions u_assertions (
    .clk        (clk),
    .reset_n    (reset_n),
    .awvalid    (awvalid),
    .awready    (awready),
    .wvalid     (wvalid),
    .wready     (wready),
    .arvalid    (arvalid),
    .arready    (arready),
    .bvalid     (bvalid),
    .bready     (bready),
    .rvalid     (rvalid),
    .rready     (rready),
    .req_valid  (req_valid),
    .resp_ready (resp_ready)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // --------------------
  // Helpers
  // --------------------
  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                             input string what);
    if (actual !== expected) begin
      errors++;
      $display("ERR %0t %s: got %h, expected %h", $time, what, actual, expected);
      $display("Checks failed");
      $fatal(1, "stopping at the first mismatch");
    end
  endtask

  task automatic stop_with_failure(input string reason);
    $display("%s", reason);
    $display("Checks failed");
    $fatal(1, "run aborted");
  endtask

  // --------------------
  // AXI4-Lite driver
  // --------------------
  task automatic axil_write(input logic [31:0] addr, input logic [31:0] data,
                            input logic [3:0] strb, output logic [1:0] resp);
    int cycles;
    @(posedge clk);
    #1;
    awaddr  = addr;
    wdata   = data;
    wstrb   = strb;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    cycles  = 0;
    @(negedge clk);
    while (!(awready && wready) && cycles < hs_timeout) begin
      cycles++;
      @(negedge clk);
    end
    if (!(awready && wready)) stop_with_failure("Timeout waiting for awready and wready");
    // Handshake on the coming edge
    @(posedge clk);
    #1;
    awvalid = 1'b0;
    wvalid  = 1'b0;
    bready  = 1'b1;
    cycles  = 0;
    @(negedge clk);
    while (!bvalid && cycles < hs_timeout) begin
      cycles++;
      @(negedge clk);
    end
    if (!bvalid) stop_with_failure("Timeout waiting for bvalid");
    resp = bresp;
    @(posedge clk);
    #1;
    bready = 1'b0;
  endtask

  task automatic axil_read(input logic [31:0] addr, output logic [31:0] data,
                           output logic [1:0] resp);
    int cycles;
    @(posedge clk);
    #1;
    araddr  = addr;
    arvalid = 1'b1;
    cycles  = 0;
    @(negedge clk);
    while (!arready && cycles < hs_timeout) begin
      cycles++;
      @(negedge clk);
    end
    if (!arready) stop_with_failure("Timeout waiting for arready");
    @(posedge clk);
    #1;
    arvalid = 1'b0;
    rready  = 1'b1;
    cycles  = 0;
    @(negedge clk);
    while (!rvalid && cycles < hs_timeout) begin
      cycles++;
      @(negedge clk);
    end
    if (!rvalid) stop_with_failure("Timeout waiting for rvalid");
    data = rdata;
    resp = rresp;
    @(posedge clk);
    #1;
    rready = 1'b0;
  endtask

  // --------------------
  // Test sections
  // --------------------
  task automatic replay_vectors();
    int          fd;
    int          fields;
    int          applied;
    int          polls;
    string       line;
    logic [7:0]  op;
    logic [31:0] addr;
    logic [31:0] wdat;
    logic [31:0] strb;
    logic [31:0] exp_data;
    logic [31:0] exp_resp;
    logic [31:0] got_data;
    logic [1:0]  got_resp;
    applied = 0;
    fd = $fopen("test/bus_vectors.txt", "r");
    if (fd == 0) stop_with_failure("Cannot open test/bus_vectors.txt");
    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      fields = $sscanf(line, "%c %h %h %h %h %h", op, addr, wdat, strb, exp_data, exp_resp);
      // Comment and blank lines do not parse into six fields
      if (fields == 6) begin
        applied++;
        if (op == "W") begin
          axil_write(addr, wdat, strb[3:0], got_resp);
          check_value({30'h0, got_resp}, exp_resp, $sformatf("bresp at %h", addr));
        end else if (op == "R") begin
          axil_read(addr, got_data, got_resp);
          check_value(got_data, exp_data, $sformatf("rdata at %h", addr));
          check_value({30'h0, got_resp}, exp_resp, $sformatf("rresp at %h", addr));
        end else if (op == "P") begin
          polls = 0;
          axil_read(addr, got_data, got_resp);
          while (got_data !== exp_data && polls < poll_limit) begin
            polls++;
            axil_read(addr, got_data, got_resp);
          end
          if (got_data !== exp_data) begin
            stop_with_failure($sformatf("Polling %h never returned %h", addr, exp_data));
          end
          check_value({30'h0, got_resp}, exp_resp, $sformatf("rresp of poll at %h", addr));
        end else begin
          stop_with_failure($sformatf("Unknown operation in vector line %0d", applied));
        end
      end
    end
    $fclose(fd);
    if (applied == 0) stop_with_failure("The vector file holds no transactions");
  endtask

  task automatic random_ram_sweep();
    logic [ram_addr_bits-1:0] addrs [32];
    logic [31:0]              data;
    logic [31:0]              got;
    logic [1:0]               resp;
    for (int i = 0; i < 32; i++) begin
      rng_state = xorshift32(rng_state);
      addrs[i]  = rng_state[ram_addr_bits-1:0];
      rng_state = xorshift32(rng_state);
      data      = rng_state;
      shadow[addrs[i]] = data;
      axil_write(ram_base | (32'(addrs[i]) << 2), data, 4'hf, resp);
      check_value({30'h0, resp}, 32'h0, "bresp in RAM sweep");
    end
    // Repeated addresses read back the last word written there
    for (int i = 0; i < 32; i++) begin
      axil_read(ram_base | (32'(addrs[i]) << 2), got, resp);
      check_value(got, shadow[addrs[i]], $sformatf("RAM sweep word %0d", addrs[i]));
      check_value({30'h0, resp}, 32'h0, "rresp in RAM sweep");
    end
  endtask

  task automatic timer_lock_test();
    logic [31:0] got;
    logic [1:0]  resp;
    axil_write(timer_pre_addr, 32'h1ff, 4'hf, resp);
    axil_write(timer_init_addr, 32'd10, 4'hf, resp);
    axil_write(timer_ctrl_addr, 32'h1, 4'hf, resp);
    axil_read(timer_stat_addr, got, resp);
    check_value(got, 32'h1, "status after start");
    axil_read(timer_cur_addr, got, resp);
    check_value({31'h0, got <= 32'd10}, 32'h1, "current at most initial");
    // Initial is locked while the timer runs
    axil_write(timer_init_addr, 32'd99, 4'hf, resp);
    axil_read(timer_init_addr, got, resp);
    check_value(got, 32'd10, "initial written while running");
    axil_write(timer_ctrl_addr, 32'h2, 4'hf, resp);
    axil_read(timer_stat_addr, got, resp);
    check_value(got, 32'h0, "status after stop");
  endtask

  // --------------------
  // Main sequence
  // --------------------
  initial begin
    errors    = 0;
    rng_state = 32'hf694;
    reset_n   = 1'b0;
    awaddr    = 32'h0;
    awvalid   = 1'b0;
    wdata     = 32'h0;
    wstrb     = 4'h0;
    wvalid    = 1'b0;
    bready    = 1'b0;
    araddr    = 32'h0;
    arvalid   = 1'b0;
    rready    = 1'b0;
    repeat (10) @(posedge clk);
    #1;
    reset_n = 1'b1;
    @(negedge clk);
    check_value({27'h0, awready, wready, arready, bvalid, rvalid}, 32'h0,
                "handshake outputs after reset");

    replay_vectors();
    random_ram_sweep();
    timer_lock_test();

    @(posedge clk);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

//--- test/bus_vectors.txt
# op addr wdata wstrb exp_rdata exp_resp, all hex, resp 0 okay and 2 slverr
# W write, R read, P poll read until exp_rdata
W 40000000 deadbeef f 00000000 0
R 40000000 00000000 0 deadbeef 0
W 40000010 11223344 f 00000000 0
W 40000010 aabbccdd 5 00000000 0
R 40000010 00000000 0 11bb33dd 0
W 40000010 eeff0000 a 00000000 0
R 40000010 00000000 0 eebb00dd 0
W 00000020 12345678 f 00000000 2
R 00000020 00000000 0 00000000 2
R 80000000 00000000 0 00000000 2
W c2000000 00000001 f 00000000 2
R c2000004 00000000 0 00000000 2
W c1000008 000001ff f 00000000 0
R c1000008 00000000 0 000001ff 0
W c100000c 00000004 f 00000000 0
W c1000000 00000001 f 00000000 0
R c1000004 00000000 0 00000001 0
R c1000010 00000000 0 00000004 0
P c1000004 00000000 0 00000000 0
R c1000010 00000000 0 00000000 0
